//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/core_pkg.sv
package core_pkg;

    // defaults for the rename top level, which passes them down as parameters.
    localparam int DEF_FETCH_WIDTH = 4;
    localparam int DEF_PREG_NUM    = 64;
    localparam int DEF_ROB_DEPTH   = 32;

    // reset mapping: architectural register i maps to physical register i.
    // the free list then holds AREG_NUM up to PREG_NUM-1, lowest number first.
    // PREG_NUM-AREG_NUM must be at least the bundle width, otherwise the stage
    // could never accept a bundle after reset.

    // PREG_NUM and ROB_DEPTH are powers of two. free list pointers and ROB
    // indices wrap by plain truncation, and the ROB direction bit is the carry.

endpackage

//--- hw/free_list.sv
module free_list import isa_pkg::*; #(
    parameter int PREG_NUM    = 64,
    parameter int FETCH_WIDTH = 4,
    localparam int PREG_BITS  = $clog2(PREG_NUM),
    localparam int CNT_BITS   = $clog2(FETCH_WIDTH + 1),
    localparam int FL_BITS    = $clog2(PREG_NUM + 1)
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  alloc_fire,
    input  logic [CNT_BITS-1:0]                   alloc_num,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] fl_prd,
    output logic [FL_BITS-1:0]                    fl_count,
    input  logic [FETCH_WIDTH-1:0]                commit_valid,
    input  logic [FETCH_WIDTH-1:0]                commit_wen,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] commit_old_prd
);

    localparam int INIT_FREE = PREG_NUM - AREG_NUM;

    logic [PREG_BITS-1:0]                 fifo_q [PREG_NUM];
    logic [PREG_BITS-1:0]                 head_q;
    logic [PREG_BITS-1:0]                 tail_q;
    logic [FL_BITS-1:0]                   count_q;
    logic [FETCH_WIDTH-1:0]               rel;
    logic [FETCH_WIDTH-1:0][CNT_BITS-1:0] rel_off;
    logic [CNT_BITS-1:0]                  rel_num;
    logic [CNT_BITS-1:0]                  take_num;

    assign rel      = commit_valid & commit_wen;
    assign take_num = alloc_fire ? alloc_num : '0;
    assign fl_count = count_q;

    // each releasing slot lands right after the ones before it.
    always_comb begin
        rel_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rel_off[i] = rel_num;
            rel_num    = rel_num + CNT_BITS'(rel[i]);
        end
    end

    // the next entries from the head, valid up to fl_count.
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            fl_prd[k] = fifo_q[head_q + PREG_BITS'(k)];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= PREG_BITS'(INIT_FREE);
            count_q <= FL_BITS'(INIT_FREE);
        end else begin
            head_q  <= head_q + PREG_BITS'(take_num);
            tail_q  <= tail_q + PREG_BITS'(rel_num);
            count_q <= count_q - FL_BITS'(take_num) + FL_BITS'(rel_num);
        end
    end

    // the first INIT_FREE slots start out holding the unmapped registers.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                fifo_q[i] <= PREG_BITS'(AREG_NUM + i);
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (rel[i]) begin
                    fifo_q[tail_q + PREG_BITS'(rel_off[i])] <= commit_old_prd[i];
                end
            end
        end
    end

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

    // integer register file of the base ISA.
    localparam int AREG_BITS = 5;
    localparam int AREG_NUM  = 1 << AREG_BITS;

    // x0 always reads as zero, so it never gets a physical register of its own.
    localparam logic [AREG_BITS-1:0] ZERO_REG = '0;

endpackage

//--- hw/rename_stage.sv
module rename_stage import isa_pkg::*; #(
    parameter int FETCH_WIDTH = 4,
    parameter int PREG_NUM    = 64,
    parameter int ROB_DEPTH   = 32,
    localparam int PREG_BITS  = $clog2(PREG_NUM),
    localparam int ROB_BITS   = $clog2(ROB_DEPTH),
    localparam int CNT_BITS   = $clog2(FETCH_WIDTH + 1),
    localparam int FL_BITS    = $clog2(PREG_NUM + 1),
    localparam int SLOT_BITS  = (FETCH_WIDTH > 1) ? $clog2(FETCH_WIDTH) : 1
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  in_valid,
    input  logic [FETCH_WIDTH-1:0]                in_en,
    input  logic [FETCH_WIDTH-1:0]                in_we,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] in_rd,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] in_rs1,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] in_rs2,
    output logic                                  in_ready,
    output logic                                  out_valid,
    output logic [FETCH_WIDTH-1:0]                out_en,
    output logic [FETCH_WIDTH-1:0]                out_wen,
    output logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] out_rd,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prs1,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prs2,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prd,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_old_prd,
    output logic [FETCH_WIDTH-1:0][ROB_BITS-1:0]  out_rob_idx,
    output logic [FETCH_WIDTH-1:0]                out_rob_dir,
    input  logic                                  out_ready,
    output logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rs1,
    output logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rs2,
    output logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rd,
    output logic [FETCH_WIDTH-1:0]                rt_we,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_wdata,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_prs1,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_prs2,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_old_prd,
    output logic                                  alloc_fire,
    output logic [CNT_BITS-1:0]                   alloc_num,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] fl_prd,
    input  logic [FL_BITS-1:0]                    fl_count,
    output logic                                  rob_fire,
    output logic [CNT_BITS-1:0]                   rob_num,
    input  logic [ROB_BITS-1:0]                   rob_tail,
    input  logic                                  rob_tail_dir,
    input  logic                                  rob_space_ok
);

    logic                                  fire;
    logic [FETCH_WIDTH-1:0]                wr;
    logic [FETCH_WIDTH-1:0]                last_wr;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] prd;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] prs1;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] prs2;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] old_prd;
    logic [FETCH_WIDTH-1:0][ROB_BITS-1:0]  rob_idx;
    logic [FETCH_WIDTH-1:0]                rob_dir;

    // ready never looks at in_valid, so the upstream can wait on it.
    assign in_ready = (!out_valid || out_ready) && (fl_count >= FL_BITS'(FETCH_WIDTH))
                      && rob_space_ok;
    assign fire       = in_valid && in_ready;
    assign alloc_fire = fire;
    assign rob_fire   = fire;

    assign rt_rs1   = in_rs1;
    assign rt_rs2   = in_rs2;
    assign rt_rd    = in_rd;
    assign rt_we    = {FETCH_WIDTH{fire}} & last_wr;
    assign rt_wdata = prd;

    // writers take free entries in slot order, enabled slots take ROB entries.
    always_comb begin
        logic [CNT_BITS-1:0] n_wr;
        logic [CNT_BITS-1:0] n_en;
        logic [ROB_BITS:0]   pos;
        n_wr = '0;
        n_en = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            wr[i]      = in_en[i] && in_we[i] && (in_rd[i] != ZERO_REG);
            prd[i]     = wr[i] ? fl_prd[SLOT_BITS'(n_wr)] : '0;
            pos        = {rob_tail_dir, rob_tail} + (ROB_BITS + 1)'(n_en);
            rob_idx[i] = pos[ROB_BITS-1:0];
            rob_dir[i] = pos[ROB_BITS];
            n_wr       = n_wr + CNT_BITS'(wr[i]);
            n_en       = n_en + CNT_BITS'(in_en[i]);
        end
        alloc_num = n_wr;
        rob_num   = n_en;
    end

    // scanning earlier slots in order lets the latest matching writer win.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            prs1[i]    = rt_prs1[i];
            prs2[i]    = rt_prs2[i];
            old_prd[i] = wr[i] ? rt_old_prd[i] : '0;
            last_wr[i] = wr[i];
            for (int j = 0; j < i; j++) begin
                if (wr[j] && in_rd[j] == in_rs1[i])
                    prs1[i] = prd[j];
                if (wr[j] && in_rd[j] == in_rs2[i])
                    prs2[i] = prd[j];
                if (wr[j] && wr[i] && in_rd[j] == in_rd[i])
                    old_prd[i] = prd[j];
            end
            // a later writer of the same register owns the table update.
            for (int j = i + 1; j < FETCH_WIDTH; j++) begin
                if (wr[j] && in_rd[j] == in_rd[i])
                    last_wr[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_en      <= in_en;
            out_wen     <= wr;
            out_rd      <= in_rd;
            out_prs1    <= prs1;
            out_prs2    <= prs2;
            out_prd     <= prd;
            out_old_prd <= old_prd;
            out_rob_idx <= rob_idx;
            out_rob_dir <= rob_dir;
        end
    end

endmodule

//--- hw/rename_table.sv
module rename_table import isa_pkg::*; #(
    parameter int FETCH_WIDTH = 4,
    parameter int PREG_NUM    = 64,
    localparam int PREG_BITS  = $clog2(PREG_NUM)
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rs1,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rs2,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rd,
    input  logic [FETCH_WIDTH-1:0]                rt_we,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_wdata,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_prs1,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_prs2,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_old_prd
);

    logic [PREG_BITS-1:0] map_q [AREG_NUM];

    // reads see the table as it was before this cycle's writes.
    // the stage handles dependences inside the bundle itself.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rt_prs1[i]    = map_q[rt_rs1[i]];
            rt_prs2[i]    = map_q[rt_rs2[i]];
            rt_old_prd[i] = map_q[rt_rd[i]];
        end
    end

    // the stage only raises rt_we for the last writer of each register,
    // so the write addresses within one cycle are distinct.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int a = 0; a < AREG_NUM; a++) begin
                map_q[a] <= PREG_BITS'(a);
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (rt_we[i]) begin
                    map_q[rt_rd[i]] <= rt_wdata[i];
                end
            end
        end
    end

endmodule

//--- hw/rename_top.sv
module rename_top import isa_pkg::*, core_pkg::*; #(
    parameter int FETCH_WIDTH = DEF_FETCH_WIDTH,
    parameter int PREG_NUM    = DEF_PREG_NUM,
    parameter int ROB_DEPTH   = DEF_ROB_DEPTH,
    localparam int PREG_BITS  = $clog2(PREG_NUM),
    localparam int ROB_BITS   = $clog2(ROB_DEPTH),
    localparam int CNT_BITS   = $clog2(FETCH_WIDTH + 1),
    localparam int FL_BITS    = $clog2(PREG_NUM + 1)
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  in_valid,
    input  logic [FETCH_WIDTH-1:0]                in_en,
    input  logic [FETCH_WIDTH-1:0]                in_we,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] in_rd,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] in_rs1,
    input  logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] in_rs2,
    output logic                                  in_ready,
    output logic                                  out_valid,
    output logic [FETCH_WIDTH-1:0]                out_en,
    output logic [FETCH_WIDTH-1:0]                out_wen,
    output logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] out_rd,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prs1,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prs2,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prd,
    output logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_old_prd,
    output logic [FETCH_WIDTH-1:0][ROB_BITS-1:0]  out_rob_idx,
    output logic [FETCH_WIDTH-1:0]                out_rob_dir,
    input  logic                                  out_ready,
    input  logic [FETCH_WIDTH-1:0]                commit_valid,
    input  logic [FETCH_WIDTH-1:0]                commit_wen,
    input  logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] commit_old_prd
);

    // map table port.
    logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rs1;
    logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rs2;
    logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] rt_rd;
    logic [FETCH_WIDTH-1:0]                rt_we;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_wdata;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_prs1;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_prs2;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] rt_old_prd;

    // free list and ROB allocation.
    logic                                  alloc_fire;
    logic [CNT_BITS-1:0]                   alloc_num;
    logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] fl_prd;
    logic [FL_BITS-1:0]                    fl_count;
    logic                                  rob_fire;
    logic [CNT_BITS-1:0]                   rob_num;
    logic [ROB_BITS-1:0]                   rob_tail;
    logic                                  rob_tail_dir;
    logic                                  rob_space_ok;

    rename_stage #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .PREG_NUM   (PREG_NUM),
        .ROB_DEPTH  (ROB_DEPTH)
    ) stage0 (.*);

    rename_table #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .PREG_NUM   (PREG_NUM)
    ) table0 (.*);

    free_list #(
        .PREG_NUM   (PREG_NUM),
        .FETCH_WIDTH(FETCH_WIDTH)
    ) free_list0 (.*);

    rob_alloc #(
        .ROB_DEPTH  (ROB_DEPTH),
        .FETCH_WIDTH(FETCH_WIDTH)
    ) rob_alloc0 (.*);

endmodule

//--- hw/rob_alloc.sv
module rob_alloc #(
    parameter int ROB_DEPTH   = 32,
    parameter int FETCH_WIDTH = 4,
    localparam int ROB_BITS   = $clog2(ROB_DEPTH),
    localparam int PTR_BITS   = ROB_BITS + 1,
    localparam int CNT_BITS   = $clog2(FETCH_WIDTH + 1)
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   rob_fire,
    input  logic [CNT_BITS-1:0]    rob_num,
    input  logic [FETCH_WIDTH-1:0] commit_valid,
    output logic [ROB_BITS-1:0]    rob_tail,
    output logic                   rob_tail_dir,
    output logic                   rob_space_ok
);

    // tail index with the direction bit as its top bit.
    logic [PTR_BITS-1:0] ptr_q;
    logic [PTR_BITS-1:0] used_q;
    logic [PTR_BITS-1:0] free_slots;
    logic [CNT_BITS-1:0] add_num;
    logic [CNT_BITS-1:0] retire_num;

    always_comb begin
        retire_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            retire_num = retire_num + CNT_BITS'(commit_valid[i]);
        end
    end

    assign add_num      = rob_fire ? rob_num : '0;
    assign rob_tail     = ptr_q[ROB_BITS-1:0];
    assign rob_tail_dir = ptr_q[ROB_BITS];
    assign free_slots   = PTR_BITS'(ROB_DEPTH) - used_q;
    assign rob_space_ok = free_slots >= PTR_BITS'(FETCH_WIDTH);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_q  <= '0;
            used_q <= '0;
        end else begin
            ptr_q  <= ptr_q + PTR_BITS'(add_num);
            used_q <= used_q + PTR_BITS'(add_num) - PTR_BITS'(retire_num);
        end
    end

endmodule

//--- list.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/rename_table.sv
hw/free_list.sv
hw/rob_alloc.sv
hw/rename_stage.sv
hw/rename_top.sv
tests/rename_assertions.sv
tests/rename_tb.sv

//--- tests/rename_assertions.sv
module rename_assertions import isa_pkg::*; #(
    parameter int FETCH_WIDTH = 4,
    parameter int PREG_NUM    = 64,
    parameter int ROB_DEPTH   = 32,
    localparam int PREG_BITS  = $clog2(PREG_NUM),
    localparam int ROB_BITS   = $clog2(ROB_DEPTH),
    localparam int CNT_BITS   = $clog2(FETCH_WIDTH + 1),
    localparam int FL_BITS    = $clog2(PREG_NUM + 1)
) (
    input logic                                  clk,
    input logic                                  arst_n,
    input logic                                  alloc_fire,
    input logic [CNT_BITS-1:0]                   alloc_num,
    input logic [FL_BITS-1:0]                    fl_count,
    input logic                                  out_valid,
    input logic                                  out_ready,
    input logic [FETCH_WIDTH-1:0]                out_en,
    input logic [FETCH_WIDTH-1:0]                out_wen,
    input logic [FETCH_WIDTH-1:0][AREG_BITS-1:0] out_rd,
    input logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prs1,
    input logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prs2,
    input logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_prd,
    input logic [FETCH_WIDTH-1:0][PREG_BITS-1:0] out_old_prd,
    input logic [FETCH_WIDTH-1:0][ROB_BITS-1:0]  out_rob_idx,
    input logic [FETCH_WIDTH-1:0]                out_rob_dir
);

    int unsigned fail_count = 0;

    // only registers outside the reset mapping can ever be free.
    a_free_bound: assert property (@(posedge clk) disable iff (!arst_n)
        fl_count <= FL_BITS'(PREG_NUM - AREG_NUM))
    else begin
        $error("free list count above the number of renameable registers");
        fail_count++;
    end

    a_alloc_covered: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_fire |-> fl_count >= FL_BITS'(alloc_num))
    else begin
        $error("allocation larger than the free list count");
        fail_count++;
    end

    a_output_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable({out_en, out_wen, out_rd,
            out_prs1, out_prs2, out_prd, out_old_prd, out_rob_idx, out_rob_dir}))
    else begin
        $error("output bundle changed while stalled");
        fail_count++;
    end

endmodule

bind rename_stage rename_assertions #(
    .FETCH_WIDTH(FETCH_WIDTH),
    .PREG_NUM   (PREG_NUM),
    .ROB_DEPTH  (ROB_DEPTH)
) chk0 (.*);

//--- tests/rename_tb.sv
module rename_tb import isa_pkg::*, core_pkg::*;;

    localparam int FW           = DEF_FETCH_WIDTH;
    localparam int PREG_BITS    = $clog2(DEF_PREG_NUM);
    localparam int ROB_BITS     = $clog2(DEF_ROB_DEPTH);
    localparam int PTR_BITS     = ROB_BITS + 1;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // about fifty bundles of up to six cycles each, with a wide margin.
    localparam int TEST_CYCLES  = 300;
    localparam int WATCH_MARGIN = 4;
    localparam logic [31:0] SEED = 32'h5f1f4938;

    logic                          clk = 1'b0;
    logic                          arst_n;
    logic                          in_valid;
    logic [FW-1:0]                 in_en;
    logic [FW-1:0]                 in_we;
    logic [FW-1:0][AREG_BITS-1:0]  in_rd;
    logic [FW-1:0][AREG_BITS-1:0]  in_rs1;
    logic [FW-1:0][AREG_BITS-1:0]  in_rs2;
    logic                          in_ready;
    logic                          out_valid;
    logic [FW-1:0]                 out_en;
    logic [FW-1:0]                 out_wen;
    logic [FW-1:0][AREG_BITS-1:0]  out_rd;
    logic [FW-1:0][PREG_BITS-1:0]  out_prs1;
    logic [FW-1:0][PREG_BITS-1:0]  out_prs2;
    logic [FW-1:0][PREG_BITS-1:0]  out_prd;
    logic [FW-1:0][PREG_BITS-1:0]  out_old_prd;
    logic [FW-1:0][ROB_BITS-1:0]   out_rob_idx;
    logic [FW-1:0]                 out_rob_dir;
    logic                          out_ready;
    logic [FW-1:0]                 commit_valid;
    logic [FW-1:0]                 commit_wen;
    logic [FW-1:0][PREG_BITS-1:0]  commit_old_prd;

    // reference model state.
    logic [PREG_BITS-1:0]          map_m [AREG_NUM];
    logic [PREG_BITS-1:0]          free_q [$];
    logic [PTR_BITS-1:0]           rob_ptr_m;
    int                            rob_used;
    logic [FW-1:0]                 pend_en [$];
    logic [FW-1:0]                 pend_wen [$];
    logic [FW-1:0][PREG_BITS-1:0]  pend_old [$];
    logic [FW-1:0]                 exp_en;
    logic [FW-1:0]                 exp_wen;
    logic [FW-1:0][AREG_BITS-1:0]  exp_rd;
    logic [FW-1:0][PREG_BITS-1:0]  exp_prs1;
    logic [FW-1:0][PREG_BITS-1:0]  exp_prs2;
    logic [FW-1:0][PREG_BITS-1:0]  exp_prd;
    logic [FW-1:0][PREG_BITS-1:0]  exp_old;
    logic [FW-1:0][ROB_BITS-1:0]   exp_idx;
    logic [FW-1:0]                 exp_dir;
    logic [31:0]                   rng;
    int                            checks;
    int                            errors;
    int                            assert_fails;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rename_top dut0 (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [FW-1:0][AREG_BITS-1:0] random_regs(input bit nonzero);
        logic [FW-1:0][AREG_BITS-1:0] r;
        for (int i = 0; i < FW; i++) begin
            if (nonzero)
                r[i] = AREG_BITS'(1 + next_rand() % (AREG_NUM - 1));
            else
                r[i] = AREG_BITS'(next_rand());
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic reset_model();
        for (int a = 0; a < AREG_NUM; a++) begin
            map_m[a] = PREG_BITS'(a);
        end
        free_q.delete();
        for (int p = AREG_NUM; p < DEF_PREG_NUM; p++) begin
            free_q.push_back(PREG_BITS'(p));
        end
        rob_ptr_m = '0;
        rob_used  = 0;
    endtask

    function automatic bit ready_expected();
        return free_q.size() >= FW && DEF_ROB_DEPTH - rob_used >= FW;
    endfunction

    // slots are renamed one after the other, so later slots see earlier writes.
    task automatic predict_bundle(input logic [FW-1:0] en, input logic [FW-1:0] we,
                                  input logic [FW-1:0][AREG_BITS-1:0] rd,
                                  input logic [FW-1:0][AREG_BITS-1:0] rs1,
                                  input logic [FW-1:0][AREG_BITS-1:0] rs2);
        logic [PTR_BITS-1:0] pos;
        pos = rob_ptr_m;
        for (int i = 0; i < FW; i++) begin
            exp_wen[i]  = en[i] && we[i] && rd[i] != ZERO_REG;
            exp_prs1[i] = map_m[rs1[i]];
            exp_prs2[i] = map_m[rs2[i]];
            exp_idx[i]  = pos[ROB_BITS-1:0];
            exp_dir[i]  = pos[ROB_BITS];
            exp_prd[i]  = '0;
            exp_old[i]  = '0;
            if (exp_wen[i]) begin
                exp_old[i]   = map_m[rd[i]];
                exp_prd[i]   = free_q.pop_front();
                map_m[rd[i]] = exp_prd[i];
            end
            if (en[i]) begin
                pos = pos + PTR_BITS'(1);
                rob_used++;
            end
        end
        rob_ptr_m = pos;
        exp_en    = en;
        exp_rd    = rd;
        pend_en.push_back(en);
        pend_wen.push_back(exp_wen);
        pend_old.push_back(exp_old);
    endtask

    task automatic check_outputs();
        check("out_valid", 32'(out_valid), 32'd1);
        check("out_en", 32'(out_en), 32'(exp_en));
        check("out_wen", 32'(out_wen), 32'(exp_wen));
        for (int i = 0; i < FW; i++) begin
            check($sformatf("out_rd[%0d]", i), 32'(out_rd[i]), 32'(exp_rd[i]));
            check($sformatf("out_prs1[%0d]", i), 32'(out_prs1[i]), 32'(exp_prs1[i]));
            check($sformatf("out_prs2[%0d]", i), 32'(out_prs2[i]), 32'(exp_prs2[i]));
            check($sformatf("out_prd[%0d]", i), 32'(out_prd[i]), 32'(exp_prd[i]));
            check($sformatf("out_old_prd[%0d]", i), 32'(out_old_prd[i]), 32'(exp_old[i]));
            check($sformatf("out_rob_idx[%0d]", i), 32'(out_rob_idx[i]), 32'(exp_idx[i]));
            check($sformatf("out_rob_dir[%0d]", i), 32'(out_rob_dir[i]), 32'(exp_dir[i]));
        end
    endtask

    task automatic drive_bundle(input logic [FW-1:0] en, input logic [FW-1:0] we,
                                input logic [FW-1:0][AREG_BITS-1:0] rd,
                                input logic [FW-1:0][AREG_BITS-1:0] rs1,
                                input logic [FW-1:0][AREG_BITS-1:0] rs2);
        @(posedge clk);
        in_valid <= 1'b1;
        in_en    <= en;
        in_we    <= we;
        in_rd    <= rd;
        in_rs1   <= rs1;
        in_rs2   <= rs2;
    endtask

    // in_ready only moves on clock edges, so the value at the falling edge decides.
    task automatic finish_bundle(input logic [FW-1:0] en, input logic [FW-1:0] we,
                                 input logic [FW-1:0][AREG_BITS-1:0] rd,
                                 input logic [FW-1:0][AREG_BITS-1:0] rs1,
                                 input logic [FW-1:0][AREG_BITS-1:0] rs2);
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        predict_bundle(en, we, rd, rs1, rs2);
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic rename_bundle(input logic [FW-1:0] en, input logic [FW-1:0] we,
                                 input logic [FW-1:0][AREG_BITS-1:0] rd,
                                 input logic [FW-1:0][AREG_BITS-1:0] rs1,
                                 input logic [FW-1:0][AREG_BITS-1:0] rs2);
        drive_bundle(en, we, rd, rs1, rs2);
        finish_bundle(en, we, rd, rs1, rs2);
    endtask

    // commits the oldest renamed bundle and frees the registers it replaced.
    task automatic retire_oldest();
        logic [FW-1:0]                en;
        logic [FW-1:0]                wen;
        logic [FW-1:0][PREG_BITS-1:0] old;
        en  = pend_en.pop_front();
        wen = pend_wen.pop_front();
        old = pend_old.pop_front();
        @(posedge clk);
        commit_valid   <= en;
        commit_wen     <= wen;
        commit_old_prd <= old;
        for (int i = 0; i < FW; i++) begin
            if (en[i] && wen[i])
                free_q.push_back(old[i]);
            if (en[i])
                rob_used--;
        end
        @(posedge clk);
        commit_valid <= '0;
        commit_wen   <= '0;
    endtask

    task automatic retire_all();
        while (pend_en.size() > 0) retire_oldest();
    endtask

    task automatic identity_after_reset();
        rename_bundle(4'hf, 4'hf, {5'd12, 5'd11, 5'd10, 5'd9},
                      {5'd7, 5'd5, 5'd3, 5'd1}, {5'd8, 5'd6, 5'd4, 5'd2});
        for (int i = 0; i < FW; i++) begin
            check($sformatf("out_prs1[%0d]", i), 32'(out_prs1[i]), 32'(2 * i + 1));
            check($sformatf("out_prs2[%0d]", i), 32'(out_prs2[i]), 32'(2 * i + 2));
            check($sformatf("out_prd[%0d]", i), 32'(out_prd[i]), 32'(AREG_NUM + i));
        end
        retire_all();
    endtask

    // x5 is written twice, read in between and read again by the next bundle.
    task automatic bundle_dependences();
        rename_bundle(4'hf, 4'hf, {5'd7, 5'd5, 5'd6, 5'd5},
                      {5'd5, 5'd6, 5'd5, 5'd1}, {5'd0, 5'd3, 5'd5, 5'd2});
        rename_bundle(4'h1, 4'h1, {5'd0, 5'd0, 5'd0, 5'd5},
                      {5'd0, 5'd0, 5'd0, 5'd5}, {5'd0, 5'd0, 5'd0, 5'd6});
        retire_all();
    endtask

    task automatic idle_slots();
        rename_bundle(4'b1101, 4'b1011, {5'd11, 5'd10, 5'd9, 5'd0},
                      {5'd1, 5'd2, 5'd3, 5'd4}, {5'd4, 5'd3, 5'd2, 5'd1});
        check("out_wen", 32'(out_wen), 32'h8);
        rename_bundle(4'hf, 4'hf, {5'd4, 5'd3, 5'd2, 5'd1},
                      {5'd11, 5'd9, 5'd10, 5'd0}, {5'd1, 5'd2, 5'd3, 5'd11});
        retire_all();
    endtask

    task automatic output_backpressure();
        @(posedge clk);
        out_ready <= 1'b0;
        rename_bundle(4'hf, 4'hf, {5'd20, 5'd21, 5'd22, 5'd23},
                      {5'd1, 5'd2, 5'd3, 5'd4}, {5'd5, 5'd6, 5'd7, 5'd8});
        drive_bundle(4'hf, 4'hf, {5'd24, 5'd25, 5'd20, 5'd21},
                     {5'd20, 5'd21, 5'd22, 5'd23}, {5'd1, 5'd2, 5'd3, 5'd4});
        repeat (4) begin
            @(negedge clk);
            check("in_ready", 32'(in_ready), 32'd0);
            check_outputs();
        end
        @(posedge clk);
        out_ready <= 1'b1;
        finish_bundle(4'hf, 4'hf, {5'd24, 5'd25, 5'd20, 5'd21},
                      {5'd20, 5'd21, 5'd22, 5'd23}, {5'd1, 5'd2, 5'd3, 5'd4});
        retire_all();
    endtask

    task automatic free_list_exhaustion();
        int n;
        n = 0;
        while (ready_expected() && n < 16) begin
            rename_bundle(4'hf, 4'hf, random_regs(1'b1), random_regs(1'b0), random_regs(1'b0));
            n++;
        end
        @(negedge clk);
        check("in_ready", 32'(in_ready), 32'd0);
        retire_oldest();
        @(negedge clk);
        check("in_ready", 32'(in_ready), 32'd1);
        // the next writers must get the registers that were just freed.
        rename_bundle(4'hf, 4'hf, random_regs(1'b1), random_regs(1'b0), random_regs(1'b0));
        retire_all();
    endtask

    task automatic rob_index_wrap();
        logic [FW-1:0] en;
        logic [FW-1:0] we;
        repeat (9) begin
            rename_bundle(4'hf, 4'h0, random_regs(1'b0), random_regs(1'b0), random_regs(1'b0));
            retire_oldest();
        end
        repeat (24) begin
            en = FW'(next_rand());
            we = FW'(next_rand());
            rename_bundle(en, we, random_regs(1'b0), random_regs(1'b0), random_regs(1'b0));
            retire_oldest();
        end
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES) * WATCH_MARGIN);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rng            = SEED;
        checks         = 0;
        errors         = 0;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_en          = '0;
        in_we          = '0;
        in_rd          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        out_ready      = 1'b1;
        commit_valid   = '0;
        commit_wen     = '0;
        commit_old_prd = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        identity_after_reset();
        bundle_dependences();
        idle_slots();
        output_backpressure();
        free_list_exhaustion();
        rob_index_wrap();
        repeat (2) @(posedge clk);
        assert_fails = int'(dut0.stage0.chk0.fail_count);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
